// ==== rv_pkg.sv ====
package rv_pkg;

   // machine word and register index widths
   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   // addi x0, x0, 0
   localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

   // the only opcodes this core decodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   // fetch to decode, 65 bits
   typedef struct packed {
      logic                  valid;
      logic [XLEN-1:0]       pc;
      logic [XLEN-1:0]       instr;
   } if_id_t;

   // decode to execute
   typedef struct packed {
      logic                  valid;
      logic [XLEN-1:0]       pc;
      logic [REG_ADDR_W-1:0] rs1;
      logic [REG_ADDR_W-1:0] rs2;
      logic [XLEN-1:0]       rs1_val;
      logic [XLEN-1:0]       rs2_val;
      logic [XLEN-1:0]       imm;
      alu_op_e               alu_op;
      logic                  use_imm;
      logic                  branch;
      logic                  branch_eq;
      logic                  reg_write;
      logic [REG_ADDR_W-1:0] rd;
   } id_ex_t;

   // execute to writeback, 38 bits
   typedef struct packed {
      logic                  write;
      logic [REG_ADDR_W-1:0] rd;
      logic [XLEN-1:0]       result;
   } ex_wb_t;

endpackage

// ==== pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
   parameter type T = logic [7:0]
) (
   input  logic clk,
   input  logic reset,
   input  logic flush_i,
   input  T     d_i,
   output T     q_o
);

   // no stall in this core, so the register loads every cycle
   always_ff @(posedge clk) begin
      if (reset || flush_i) begin
         // all zero payload is a bubble, valid bit included
         q_o <= '0;
      end else begin
         q_o <= d_i;
      end
   end

endmodule

// ==== rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      start_i,
   input  logic [rv_pkg::XLEN-1:0]   start_pc_i,
   input  logic                      redirect_i,
   input  logic [rv_pkg::XLEN-1:0]   target_i,
   input  logic [rv_pkg::XLEN-1:0]   imem_data_i,
   output logic [rv_pkg::XLEN-1:0]   imem_addr_o,
   output rv_pkg::if_id_t            if_o
);

   logic [rv_pkg::XLEN-1:0] pc_q;
   logic                    running_q;

   // start wins over a redirect still in flight from the old program
   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q      <= '0;
         running_q <= 1'b0;
      end else if (start_i) begin
         pc_q      <= start_pc_i;
         running_q <= 1'b1;
      end else if (running_q) begin
         if (redirect_i) begin
            pc_q <= target_i;
         end else begin
            pc_q <= pc_q + 32'd4;
         end
      end
   end

   assign imem_addr_o = pc_q;

   // imem answers in the same cycle
   always_comb begin
      if_o.valid = running_q;
      if_o.pc    = pc_q;
      if_o.instr = imem_data_i;
   end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
   input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
   input  logic                          we_i,
   input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
   input  logic [rv_pkg::XLEN-1:0]       wdata_i,
   output logic [rv_pkg::XLEN-1:0]       rdata1_o,
   output logic [rv_pkg::XLEN-1:0]       rdata2_o
);

   // x1..x31, x0 has no storage
   logic [rv_pkg::XLEN-1:0] regs [1:31];
   logic                    wr_en;

   assign wr_en = we_i && (rd_i != '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[rd_i] <= wdata_i;
      end
   end

   // write-through so decode sees the value retiring this cycle
   always_comb begin
      if (rs1_i == '0) begin
         rdata1_o = '0;
      end else if (wr_en && (rd_i == rs1_i)) begin
         rdata1_o = wdata_i;
      end else begin
         rdata1_o = regs[rs1_i];
      end

      if (rs2_i == '0) begin
         rdata2_o = '0;
      end else if (wr_en && (rd_i == rs2_i)) begin
         rdata2_o = wdata_i;
      end else begin
         rdata2_o = regs[rs2_i];
      end
   end

endmodule

// ==== rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
   input  rv_pkg::if_id_t                if_i,
   output logic [rv_pkg::REG_ADDR_W-1:0] rs1_o,
   output logic [rv_pkg::REG_ADDR_W-1:0] rs2_o,
   input  logic [rv_pkg::XLEN-1:0]       rdata1_i,
   input  logic [rv_pkg::XLEN-1:0]       rdata2_i,
   output rv_pkg::id_ex_t                id_o
);

   logic [6:0]              opcode;
   logic [2:0]              funct3;
   logic [6:0]              funct7;
   logic [rv_pkg::XLEN-1:0] imm_i;
   logic [rv_pkg::XLEN-1:0] imm_b;
   logic                    supported;

   assign opcode = if_i.instr[6:0];
   assign funct3 = if_i.instr[14:12];
   assign funct7 = if_i.instr[31:25];
   assign rs1_o  = if_i.instr[19:15];
   assign rs2_o  = if_i.instr[24:20];

   // sign-extended immediates
   assign imm_i = {{20{if_i.instr[31]}}, if_i.instr[31:20]};
   assign imm_b = {{19{if_i.instr[31]}}, if_i.instr[31], if_i.instr[7],
                   if_i.instr[30:25], if_i.instr[11:8], 1'b0};

   always_comb begin
      supported      = 1'b0;
      id_o.pc        = if_i.pc;
      id_o.rs1       = rs1_o;
      id_o.rs2       = rs2_o;
      id_o.rs1_val   = rdata1_i;
      id_o.rs2_val   = rdata2_i;
      id_o.imm       = imm_i;
      id_o.alu_op    = rv_pkg::ALU_ADD;
      id_o.use_imm   = 1'b0;
      id_o.branch    = 1'b0;
      id_o.branch_eq = 1'b0;
      id_o.reg_write = 1'b0;
      id_o.rd        = if_i.instr[11:7];

      case (opcode)
         rv_pkg::OPC_OP: begin
            id_o.reg_write = 1'b1;
            case (funct3)
               3'b000: begin
                  // funct7 bit 5 picks sub
                  supported   = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                  id_o.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
               end
               3'b100: begin
                  supported   = (funct7 == 7'b0000000);
                  id_o.alu_op = rv_pkg::ALU_XOR;
               end
               3'b110: begin
                  supported   = (funct7 == 7'b0000000);
                  id_o.alu_op = rv_pkg::ALU_OR;
               end
               3'b111: begin
                  supported   = (funct7 == 7'b0000000);
                  id_o.alu_op = rv_pkg::ALU_AND;
               end
               default: supported = 1'b0;
            endcase
         end
         rv_pkg::OPC_OP_IMM: begin
            id_o.reg_write = 1'b1;
            id_o.use_imm   = 1'b1;
            supported      = 1'b1;
            case (funct3)
               3'b000:  id_o.alu_op = rv_pkg::ALU_ADD;
               3'b100:  id_o.alu_op = rv_pkg::ALU_XOR;
               3'b110:  id_o.alu_op = rv_pkg::ALU_OR;
               3'b111:  id_o.alu_op = rv_pkg::ALU_AND;
               default: supported = 1'b0;
            endcase
         end
         rv_pkg::OPC_BRANCH: begin
            // beq and bne only
            id_o.imm       = imm_b;
            id_o.branch    = 1'b1;
            id_o.branch_eq = (funct3 == 3'b000);
            supported      = (funct3 == 3'b000) || (funct3 == 3'b001);
         end
         default: supported = 1'b0;
      endcase

      // anything else travels on as a bubble
      id_o.valid = if_i.valid && supported;
   end

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
   input  rv_pkg::id_ex_t          id_i,
   input  rv_pkg::ex_wb_t          wb_i,
   output rv_pkg::ex_wb_t          ex_o,
   output logic                    redirect_o,
   output logic [rv_pkg::XLEN-1:0] target_o
);

   logic                    fwd_a;
   logic                    fwd_b;
   logic [rv_pkg::XLEN-1:0] op_a;
   logic [rv_pkg::XLEN-1:0] op_b_reg;
   logic [rv_pkg::XLEN-1:0] op_b;
   logic [rv_pkg::XLEN-1:0] alu_res;
   logic                    equal;

   // bypass from the EX/WB register, x0 is never forwarded
   assign fwd_a = wb_i.write && (wb_i.rd != '0) && (wb_i.rd == id_i.rs1);
   assign fwd_b = wb_i.write && (wb_i.rd != '0) && (wb_i.rd == id_i.rs2);

   assign op_a     = fwd_a ? wb_i.result : id_i.rs1_val;
   assign op_b_reg = fwd_b ? wb_i.result : id_i.rs2_val;
   assign op_b     = id_i.use_imm ? id_i.imm : op_b_reg;

   always_comb begin
      case (id_i.alu_op)
         rv_pkg::ALU_ADD: alu_res = op_a + op_b;
         rv_pkg::ALU_SUB: alu_res = op_a - op_b;
         rv_pkg::ALU_AND: alu_res = op_a & op_b;
         rv_pkg::ALU_OR:  alu_res = op_a | op_b;
         rv_pkg::ALU_XOR: alu_res = op_a ^ op_b;
         default:         alu_res = '0;
      endcase
   end

   // branch compare always uses the register operands
   assign equal = (op_a == op_b_reg);

   // beq taken on equal, bne on not equal
   assign redirect_o = id_i.valid && id_i.branch && (equal == id_i.branch_eq);
   assign target_o   = id_i.pc + id_i.imm;

   // writes to x0 are dropped here so they never retire
   always_comb begin
      ex_o.write  = id_i.valid && id_i.reg_write && (id_i.rd != '0);
      ex_o.rd     = id_i.rd;
      ex_o.result = alu_res;
   end

endmodule

// ==== rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          start_i,
   input  logic [rv_pkg::XLEN-1:0]       start_pc_i,
   output logic [rv_pkg::XLEN-1:0]       imem_addr_o,
   input  logic [rv_pkg::XLEN-1:0]       imem_data_i,
   output logic                          wb_valid_o,
   output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
   output logic [rv_pkg::XLEN-1:0]       wb_data_o
);

   rv_pkg::if_id_t if_d;
   rv_pkg::if_id_t if_q;
   rv_pkg::id_ex_t id_d;
   rv_pkg::id_ex_t id_q;
   rv_pkg::ex_wb_t ex_d;
   rv_pkg::ex_wb_t ex_q;

   logic [rv_pkg::REG_ADDR_W-1:0] rs1;
   logic [rv_pkg::REG_ADDR_W-1:0] rs2;
   logic [rv_pkg::XLEN-1:0]       rdata1;
   logic [rv_pkg::XLEN-1:0]       rdata2;
   logic                          redirect;
   logic [rv_pkg::XLEN-1:0]       target;
   logic                          flush_front;

   // taken branch or a restart kills the two younger stages
   assign flush_front = redirect || start_i;

   rv_fetch u_fetch (
      .clk         (clk),
      .reset       (reset),
      .start_i     (start_i),
      .start_pc_i  (start_pc_i),
      .redirect_i  (redirect),
      .target_i    (target),
      .imem_data_i (imem_data_i),
      .imem_addr_o (imem_addr_o),
      .if_o        (if_d)
   );

   pipe_reg #(.T(rv_pkg::if_id_t)) u_if_id (
      .clk     (clk),
      .reset   (reset),
      .flush_i (flush_front),
      .d_i     (if_d),
      .q_o     (if_q)
   );

   rv_decode u_decode (
      .if_i     (if_q),
      .rs1_o    (rs1),
      .rs2_o    (rs2),
      .rdata1_i (rdata1),
      .rdata2_i (rdata2),
      .id_o     (id_d)
   );

   rv_regfile u_regfile (
      .clk      (clk),
      .reset    (reset),
      .rs1_i    (rs1),
      .rs2_i    (rs2),
      .we_i     (ex_q.write),
      .rd_i     (ex_q.rd),
      .wdata_i  (ex_q.result),
      .rdata1_o (rdata1),
      .rdata2_o (rdata2)
   );

   pipe_reg #(.T(rv_pkg::id_ex_t)) u_id_ex (
      .clk     (clk),
      .reset   (reset),
      .flush_i (flush_front),
      .d_i     (id_d),
      .q_o     (id_q)
   );

   rv_execute u_execute (
      .id_i       (id_q),
      .wb_i       (ex_q),
      .ex_o       (ex_d),
      .redirect_o (redirect),
      .target_o   (target)
   );

   // the branch itself is older than the flush and still retires nothing
   pipe_reg #(.T(rv_pkg::ex_wb_t)) u_ex_wb (
      .clk     (clk),
      .reset   (reset),
      .flush_i (1'b0),
      .d_i     (ex_d),
      .q_o     (ex_q)
   );

   assign wb_valid_o = ex_q.write;
   assign wb_rd_o    = ex_q.rd;
   assign wb_data_o  = ex_q.result;

endmodule

// ==== rv_core_assertions.sv ====
`timescale 1ns/1ps

module rv_core_assertions (
   input logic                          clk,
   input logic                          reset,
   input logic                          wb_valid_i,
   input logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
   input logic [rv_pkg::XLEN-1:0]       imem_addr_i
);

   // retire port quiet right after a reset edge
   a_reset_quiet: assert property (@(posedge clk) reset |=> !wb_valid_i)
      else $error("retire strobe high in the cycle after reset");

   a_no_x0_retire: assert property (@(posedge clk) disable iff (reset)
                                    wb_valid_i |-> (wb_rd_i != '0))
      else $error("retire port reported a write to x0");

   a_addr_aligned: assert property (@(posedge clk) disable iff (reset)
                                    imem_addr_i[1:0] == 2'b00)
      else $error("instruction address is not word aligned");

endmodule

bind rv_core_top rv_core_assertions u_assertions (
   .clk         (clk),
   .reset       (reset),
   .wb_valid_i  (wb_valid_o),
   .wb_rd_i     (wb_rd_o),
   .imem_addr_i (imem_addr_o)
);

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

   localparam int NUM_PROGS   = 20;
   localparam int RESET_CYC   = 10;
   localparam int QUIET_LOOPS = 8;
   localparam int CYCLE_LIMIT = NUM_PROGS * (RESET_CYC + 64 * 3 + 40);
   // byte address of the self-loop branch in word 63
   localparam logic [31:0] LOOP_ADDR = 32'd252;

   logic        clk;
   logic        reset;
   logic        start;
   logic [31:0] start_pc;
   logic [31:0] imem_addr;
   logic [31:0] imem_data;
   logic        wb_valid;
   logic [4:0]  wb_rd;
   logic [31:0] wb_data;

   logic [31:0] rng_state;
   int          cycles = 0;

   // program plus the fields each word was built from
   logic [31:0] prog [64];
   int          kind_mem [64];
   logic [2:0]  rd_mem [64];
   logic [2:0]  rs1_mem [64];
   logic [2:0]  rs2_mem [64];
   logic [31:0] imm_mem [64];

   // expected retire stream from the model
   logic [4:0]  exp_rd [$];
   logic [31:0] exp_data [$];

   rv_core_top u_dut (
      .clk         (clk),
      .reset       (reset),
      .start_i     (start),
      .start_pc_i  (start_pc),
      .imem_addr_o (imem_addr),
      .imem_data_i (imem_data),
      .wb_valid_o  (wb_valid),
      .wb_rd_o     (wb_rd),
      .wb_data_o   (wb_data)
   );

   // fetches past the program see a nop
   assign imem_data = (imem_addr[31:8] == 24'd0) ? prog[imem_addr[7:2]] : rv_pkg::NOP_INSTR;

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, the retire stream never completed", cycles);
         $display("TEST RESULT: FAIL");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] time %0t: %s expected %h, got %h", $time, name, expected, actual);
         $display("TEST RESULT: FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // kinds 0..4 add sub and or xor, 5..8 addi andi ori xori, 9 beq, 10 bne
   function automatic logic [31:0] encode(input int kind, input logic [2:0] rd,
                                          input logic [2:0] rs1, input logic [2:0] rs2,
                                          input logic [31:0] imm);
      logic [2:0] f3;
      logic [6:0] f7;
      case (kind)
         0, 1, 5, 9: f3 = 3'b000;
         2, 6:       f3 = 3'b111;
         3, 7:       f3 = 3'b110;
         4, 8:       f3 = 3'b100;
         default:    f3 = 3'b001;
      endcase
      f7 = (kind == 1) ? 7'b0100000 : 7'b0000000;
      if (kind < 5) begin
         return {f7, 2'b00, rs2, 2'b00, rs1, f3, 2'b00, rd, rv_pkg::OPC_OP};
      end else if (kind < 9) begin
         return {imm[11:0], 2'b00, rs1, f3, 2'b00, rd, rv_pkg::OPC_OP_IMM};
      end else begin
         return {imm[12], imm[10:5], 2'b00, rs2, 2'b00, rs1, f3, imm[4:1], imm[11],
                 rv_pkg::OPC_BRANCH};
      end
   endfunction

   task automatic gen_program();
      logic [31:0] r;
      int          span;
      for (int i = 0; i < 63; i++) begin
         kind_mem[i] = int'(next_rand() % 32'd11);
         r = next_rand();
         // only x0..x7 so dependences are frequent
         rd_mem[i]  = r[2:0];
         rs1_mem[i] = r[5:3];
         rs2_mem[i] = r[8:6];
         if (kind_mem[i] >= 9) begin
            // forward only and never past word 63
            span = 63 - i;
            imm_mem[i] = (1 + int'(next_rand() % 32'(span))) * 4;
         end else begin
            imm_mem[i] = {{20{r[31]}}, r[31:20]};
         end
      end
      // beq x0, x0, 0 ends the program
      kind_mem[63] = 9;
      rd_mem[63]   = 3'd0;
      rs1_mem[63]  = 3'd0;
      rs2_mem[63]  = 3'd0;
      imm_mem[63]  = 32'd0;
      for (int i = 0; i < 64; i++) begin
         prog[i] = encode(kind_mem[i], rd_mem[i], rs1_mem[i], rs2_mem[i], imm_mem[i]);
      end
   endtask

   // instruction-set model that collects the writes which must retire
   task automatic run_model(input int start_idx);
      logic [31:0] regs [8];
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      int          idx;
      for (int i = 0; i < 8; i++) begin
         regs[i] = 32'd0;
      end
      exp_rd.delete();
      exp_data.delete();
      idx = start_idx;
      while (idx != 63) begin
         a = regs[rs1_mem[idx]];
         if (kind_mem[idx] >= 5 && kind_mem[idx] < 9) begin
            b = imm_mem[idx];
         end else begin
            b = regs[rs2_mem[idx]];
         end
         case (kind_mem[idx])
            0, 5:    res = a + b;
            1:       res = a - b;
            2, 6:    res = a & b;
            3, 7:    res = a | b;
            default: res = a ^ b;
         endcase
         if (kind_mem[idx] >= 9) begin
            if ((a == b) == (kind_mem[idx] == 9)) begin
               idx += int'(imm_mem[idx] >> 2);
            end else begin
               idx++;
            end
         end else begin
            if (rd_mem[idx] != 3'd0) begin
               regs[rd_mem[idx]] = res;
               exp_rd.push_back({2'b00, rd_mem[idx]});
               exp_data.push_back(res);
            end
            idx++;
         end
      end
   endtask

   initial begin
      int start_idx;
      int quiet;
      rng_state = 32'd19;
      reset     = 1'b1;
      start     = 1'b0;
      start_pc  = 32'd0;
      for (int p = 0; p < NUM_PROGS; p++) begin
         reset = 1'b1;
         gen_program();
         start_idx = int'(next_rand() % 32'd64);
         run_model(start_idx);
         repeat (RESET_CYC) @(negedge clk);
         reset = 1'b0;
         check("imem_addr_o", 32'd0, imem_addr);
         start    = 1'b1;
         start_pc = start_idx * 4;
         @(negedge clk);
         start = 1'b0;
         check("imem_addr_o", start_pc, imem_addr);
         while (exp_rd.size() > 0) begin
            if (wb_valid) begin
               check("wb_rd_o", 32'(exp_rd[0]), 32'(wb_rd));
               check("wb_data_o", exp_data[0], wb_data);
               void'(exp_rd.pop_front());
               void'(exp_data.pop_front());
            end
            @(negedge clk);
         end
         // nothing more may retire once the core spins in the self loop
         quiet = 0;
         while (quiet < QUIET_LOOPS) begin
            check("wb_valid_o", 32'd0, 32'(wb_valid));
            if (imem_addr == LOOP_ADDR) begin
               quiet++;
            end
            @(negedge clk);
         end
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== compile.f ====
rv_pkg.sv
pipe_reg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_core_top.sv
rv_core_assertions.sv
tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rv_core -f compile.f -o sim_rv_core \
   && ./obj_dir/sim_rv_core \
   && echo "simulation exited cleanly" \
   || { echo "simulation exited with an error"; exit 1; }
